//--- src/rv_exec_pkg.sv
// widths, decode bus field positions and op codes; the decode bus layout is fixed by the decoder
`default_nettype none

package rv_exec_pkg;

  localparam int WORD_WD       = 64;
  localparam int GPR_ADDR_WD   = 5;
  localparam int CSR_ADDR_WD   = 12;
  localparam int SRAM_ADDR_WD  = 32;
  localparam int SRAM_WMASK_WD = 8;

  localparam int DS_TO_ES_BUS_WD = 359;
  // rd, csr, 4 control bits + mem_op, 3 data words, ebreak, invalid, addr[2:0]
  localparam int ES_TO_MS_BUS_WD = GPR_ADDR_WD + CSR_ADDR_WD + 7 + 3 * WORD_WD + 5;

  // decode bus field lsbs, highest field first
  localparam int DS_RS1DATA_LSB   = 295;
  localparam int DS_RS2DATA_LSB   = 231;
  localparam int DS_CSRRDATA_LSB  = 167;
  localparam int DS_IMM_LSB       = 103;
  localparam int DS_PC_LSB        = 39;
  localparam int DS_SRC1_SEL_LSB  = 38;
  localparam int DS_SRC2_SEL_LSB  = 36;  // 2 bits
  localparam int DS_WORD_CUT_LSB  = 35;
  localparam int DS_ALU_OP_LSB    = 30;  // 5 bits
  localparam int DS_RD_LSB        = 25;
  localparam int DS_CSR_LSB       = 13;
  localparam int DS_GPR_WEN_LSB   = 12;
  localparam int DS_CSR_WEN_LSB   = 11;
  localparam int DS_MEM_REN_LSB   = 10;
  localparam int DS_MEM_WEN_LSB   = 9;
  localparam int DS_MEM_OP_LSB    = 6;   // 3 bits
  localparam int DS_CSR_INST_LSB  = 5;
  localparam int DS_CSR_OP_LSB    = 2;   // 3 bits
  localparam int DS_EBREAK_LSB    = 1;
  localparam int DS_INVALID_LSB   = 0;

  typedef enum logic [4:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS2
  } alu_op_e;

  typedef enum logic {SRC1_RS1, SRC1_PC} src1_sel_e;

  typedef enum logic [1:0] {SRC2_RS2, SRC2_IMM, SRC2_FOUR} src2_sel_e;

  typedef enum logic [2:0] {CSR_NONE, CSR_RW, CSR_RS, CSR_RC} csr_op_e;

  // [1:0] size, [2] unsigned load
  typedef enum logic [2:0] {
    MEM_B  = 3'b000, MEM_H  = 3'b001, MEM_W  = 3'b010, MEM_D = 3'b011,
    MEM_BU = 3'b100, MEM_HU = 3'b101, MEM_WU = 3'b110
  } mem_op_e;

endpackage

`default_nettype wire

//--- src/ex_unit.sv
// purely combinational; word cut applies to every op, the decoder only sets it for add/sub/shifts
`timescale 1ns/1ps
`default_nettype none

module ex_unit (
  input  logic [rv_exec_pkg::WORD_WD-1:0] i_rs1data,
  input  logic [rv_exec_pkg::WORD_WD-1:0] i_rs2data,
  input  logic [rv_exec_pkg::WORD_WD-1:0] i_imm,
  input  logic [rv_exec_pkg::WORD_WD-1:0] i_pc,
  input  logic [rv_exec_pkg::WORD_WD-1:0] i_csrrdata,
  input  logic                            i_alu_src1_sel,
  input  logic [1:0]                      i_alu_src2_sel,
  input  logic [4:0]                      i_alu_op,
  input  logic                            i_alu_word_cut_sel,
  input  logic [2:0]                      i_csr_op,
  output logic [rv_exec_pkg::WORD_WD-1:0] o_alu_result,
  output logic [rv_exec_pkg::WORD_WD-1:0] o_csr_result
);

  import rv_exec_pkg::*;

  logic [WORD_WD-1:0] src1;
  logic [WORD_WD-1:0] src2;
  logic [WORD_WD-1:0] alu_raw;
  logic [WORD_WD-1:0] sll64;
  logic [WORD_WD-1:0] srl64;
  logic [WORD_WD-1:0] sra64;
  logic [31:0]        sll32;
  logic [31:0]        srl32;
  logic [31:0]        sra32;

  assign src1 = (i_alu_src1_sel == SRC1_PC) ? i_pc : i_rs1data;

  always_comb begin
    unique case (i_alu_src2_sel)
      SRC2_RS2:  src2 = i_rs2data;
      SRC2_IMM:  src2 = i_imm;
      SRC2_FOUR: src2 = 64'd4;  // return address for jal/jalr
      default:   src2 = '0;
    endcase
  end

  // full width shifts use 6 bits of amount
  assign sll64 = src1 << src2[5:0];
  assign srl64 = src1 >> src2[5:0];
  assign sra64 = $signed(src1) >>> src2[5:0];

  // word forms shift only the low half, amount is 5 bits
  assign sll32 = src1[31:0] << src2[4:0];
  assign srl32 = src1[31:0] >> src2[4:0];
  assign sra32 = $signed(src1[31:0]) >>> src2[4:0];

  always_comb begin
    unique case (i_alu_op)
      ALU_ADD:   alu_raw = src1 + src2;
      ALU_SUB:   alu_raw = src1 - src2;
      ALU_SLL:   alu_raw = i_alu_word_cut_sel ? {32'b0, sll32} : sll64;
      ALU_SLT:   alu_raw = {63'b0, $signed(src1) < $signed(src2)};
      ALU_SLTU:  alu_raw = {63'b0, src1 < src2};
      ALU_XOR:   alu_raw = src1 ^ src2;
      ALU_SRL:   alu_raw = i_alu_word_cut_sel ? {32'b0, srl32} : srl64;
      ALU_SRA:   alu_raw = i_alu_word_cut_sel ? {32'b0, sra32} : sra64;
      ALU_OR:    alu_raw = src1 | src2;
      ALU_AND:   alu_raw = src1 & src2;
      ALU_PASS2: alu_raw = src2;  // lui
      default:   alu_raw = '0;
    endcase
  end

  // low 32 bits of add/sub match the word result, so one sign extension covers all
  assign o_alu_result = i_alu_word_cut_sel ? {{32{alu_raw[31]}}, alu_raw[31:0]} : alu_raw;

  // csr read-modify-write, the mask always comes from rs1
  always_comb begin
    unique case (i_csr_op)
      CSR_RW:  o_csr_result = i_rs1data;
      CSR_RS:  o_csr_result = i_csrrdata | i_rs1data;
      CSR_RC:  o_csr_result = i_csrrdata & ~i_rs1data;
      default: o_csr_result = i_csrrdata;  // no write-back change
    endcase
  end

endmodule

`default_nettype wire

//--- src/lsu_store.sv
// store lane builder; assumes the address offset is aligned to the access size
`timescale 1ns/1ps
`default_nettype none

module lsu_store (
  input  logic [2:0]                            i_mem_op,
  input  logic [2:0]                            i_waddr_align,
  input  logic [rv_exec_pkg::WORD_WD-1:0]       i_wdata,
  output logic [rv_exec_pkg::SRAM_WMASK_WD-1:0] o_wmask,
  output logic [rv_exec_pkg::WORD_WD-1:0]       o_wdata
);

  import rv_exec_pkg::*;

  logic [SRAM_WMASK_WD-1:0] base_mask;

  // data is replicated across the word, the mask picks the lanes
  always_comb begin
    unique case (i_mem_op)
      MEM_B, MEM_BU: begin
        base_mask = 8'h01;
        o_wdata   = {8{i_wdata[7:0]}};
      end
      MEM_H, MEM_HU: begin
        base_mask = 8'h03;
        o_wdata   = {4{i_wdata[15:0]}};
      end
      MEM_W, MEM_WU: begin
        base_mask = 8'h0f;
        o_wdata   = {2{i_wdata[31:0]}};
      end
      default: begin
        base_mask = 8'hff;
        o_wdata   = i_wdata;
      end
    endcase
  end

  assign o_wmask = base_mask << i_waddr_align;  // first lane at the byte offset

endmodule

`default_nettype wire

//--- src/data_sram.sv
// one read or one write per cycle; read data arrives the cycle after ren, no reset on contents
`timescale 1ns/1ps
`default_nettype none

module data_sram #(
  parameter int MEM_DEPTH = 512
) (
  input  logic                                  i_clk,
  input  logic [rv_exec_pkg::SRAM_ADDR_WD-1:0]  i_addr,
  input  logic                                  i_ren,
  input  logic                                  i_wen,
  input  logic [rv_exec_pkg::SRAM_WMASK_WD-1:0] i_wmask,
  input  logic [rv_exec_pkg::WORD_WD-1:0]       i_wdata,
  output logic [rv_exec_pkg::WORD_WD-1:0]       o_rdata
);

  import rv_exec_pkg::*;

  localparam int IDX_WD = $clog2(MEM_DEPTH);

  logic [WORD_WD-1:0] mem [MEM_DEPTH];
  logic [IDX_WD-1:0]  idx;

  assign idx = i_addr[IDX_WD+2:3];  // word index, byte offset dropped

  always_ff @(posedge i_clk) begin
    if (i_wen) begin
      for (int b = 0; b < SRAM_WMASK_WD; b++) begin
        if (i_wmask[b]) begin
          mem[idx][b*8 +: 8] <= i_wdata[b*8 +: 8];
        end
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_ren) begin
      o_rdata <= mem[idx];
    end
  end

  // upper address bits must not alias onto the array
  a_index_in_range: assert property (@(posedge i_clk)
    (i_ren || i_wen) |-> (i_addr[SRAM_ADDR_WD-1:3] < MEM_DEPTH))
    else $error("data sram index out of range, addr %h", i_addr);

  a_no_read_write: assert property (@(posedge i_clk) !(i_ren && i_wen))
    else $error("data sram read and write in the same cycle");

endmodule

`default_nettype wire

//--- src/ex_stage.sv
// combinational execute stage; memory requests leave here, load data returns to the memory stage
`timescale 1ns/1ps
`default_nettype none

module ex_stage (
  input  logic                                    i_ex_valid,
  input  logic [rv_exec_pkg::DS_TO_ES_BUS_WD-1:0] i_ds_to_es_bus,
  output logic                                    o_es_valid,
  output logic [rv_exec_pkg::ES_TO_MS_BUS_WD-1:0] o_es_to_ms_bus,
  output logic [rv_exec_pkg::SRAM_ADDR_WD-1:0]    o_data_sram_addr,
  output logic                                    o_data_sram_ren,
  output logic                                    o_data_sram_wen,
  output logic [rv_exec_pkg::SRAM_WMASK_WD-1:0]   o_data_sram_wmask,
  output logic [rv_exec_pkg::WORD_WD-1:0]         o_data_sram_wdata
);

  import rv_exec_pkg::*;

  logic [WORD_WD-1:0]     es_rs1data;
  logic [WORD_WD-1:0]     es_rs2data;
  logic [WORD_WD-1:0]     es_csrrdata;
  logic [GPR_ADDR_WD-1:0] es_rd;
  logic [CSR_ADDR_WD-1:0] es_csr;
  logic                   es_mem_ren;
  logic                   es_mem_wen;
  logic [2:0]             es_mem_op;
  logic [WORD_WD-1:0]     es_alu_result;
  logic [WORD_WD-1:0]     es_csr_result;
  logic                   es_misalign;

  assign es_rs1data  = i_ds_to_es_bus[DS_RS1DATA_LSB +: WORD_WD];
  assign es_rs2data  = i_ds_to_es_bus[DS_RS2DATA_LSB +: WORD_WD];
  assign es_csrrdata = i_ds_to_es_bus[DS_CSRRDATA_LSB +: WORD_WD];
  assign es_rd       = i_ds_to_es_bus[DS_RD_LSB +: GPR_ADDR_WD];
  assign es_csr      = i_ds_to_es_bus[DS_CSR_LSB +: CSR_ADDR_WD];
  assign es_mem_ren  = i_ds_to_es_bus[DS_MEM_REN_LSB];
  assign es_mem_wen  = i_ds_to_es_bus[DS_MEM_WEN_LSB];
  assign es_mem_op   = i_ds_to_es_bus[DS_MEM_OP_LSB +: 3];

  ex_unit u_ex_unit (
    .i_rs1data          (es_rs1data),
    .i_rs2data          (es_rs2data),
    .i_imm              (i_ds_to_es_bus[DS_IMM_LSB +: WORD_WD]),
    .i_pc               (i_ds_to_es_bus[DS_PC_LSB +: WORD_WD]),
    .i_csrrdata         (es_csrrdata),
    .i_alu_src1_sel     (i_ds_to_es_bus[DS_SRC1_SEL_LSB]),
    .i_alu_src2_sel     (i_ds_to_es_bus[DS_SRC2_SEL_LSB +: 2]),
    .i_alu_op           (i_ds_to_es_bus[DS_ALU_OP_LSB +: 5]),
    .i_alu_word_cut_sel (i_ds_to_es_bus[DS_WORD_CUT_LSB]),
    .i_csr_op           (i_ds_to_es_bus[DS_CSR_OP_LSB +: 3]),
    .o_alu_result       (es_alu_result),
    .o_csr_result       (es_csr_result)
  );

  lsu_store u_lsu_store (
    .i_mem_op      (es_mem_op),
    .i_waddr_align (es_alu_result[2:0]),  // rs1 + imm
    .i_wdata       (es_rs2data),
    .o_wmask       (o_data_sram_wmask),
    .o_wdata       (o_data_sram_wdata)
  );

  assign o_data_sram_addr = es_alu_result[SRAM_ADDR_WD-1:0];
  assign o_data_sram_ren  = i_ex_valid & es_mem_ren;
  assign o_data_sram_wen  = i_ex_valid & es_mem_wen;

  assign o_es_valid     = i_ex_valid;
  assign o_es_to_ms_bus = {es_rd, es_csr,
                           i_ds_to_es_bus[DS_GPR_WEN_LSB],
                           i_ds_to_es_bus[DS_CSR_WEN_LSB],
                           es_mem_ren, es_mem_op,
                           i_ds_to_es_bus[DS_CSR_INST_LSB],
                           es_csrrdata, es_alu_result, es_csr_result,
                           i_ds_to_es_bus[DS_EBREAK_LSB],
                           i_ds_to_es_bus[DS_INVALID_LSB],
                           es_alu_result[2:0]};  // load lane offset

  always_comb begin
    unique case (es_mem_op)
      MEM_B, MEM_BU: es_misalign = 1'b0;
      MEM_H, MEM_HU: es_misalign = es_alu_result[0];
      MEM_W, MEM_WU: es_misalign = |es_alu_result[1:0];
      default:       es_misalign = |es_alu_result[2:0];
    endcase
  end

  // store mask and load extraction both rely on this
  always_comb begin
    if (i_ex_valid && (es_mem_ren || es_mem_wen)) begin
      a_aligned: assert #0 (!es_misalign)
        else $error("misaligned access, addr %h mem_op %0d", o_data_sram_addr, es_mem_op);
    end
  end

endmodule

`default_nettype wire

//--- src/mem_stage.sv
// one-cycle memory stage; load data must arrive the cycle after the request, no stall path
`timescale 1ns/1ps
`default_nettype none

module mem_stage (
  input  logic                                    i_clk,
  input  logic                                    i_reset,
  input  logic                                    i_es_valid,
  input  logic [rv_exec_pkg::ES_TO_MS_BUS_WD-1:0] i_es_to_ms_bus,
  input  logic [rv_exec_pkg::WORD_WD-1:0]         i_data_sram_rdata,
  output logic                                    o_ws_valid,
  output logic [rv_exec_pkg::GPR_ADDR_WD-1:0]     o_ws_rd,
  output logic                                    o_ws_gpr_wen,
  output logic [rv_exec_pkg::WORD_WD-1:0]         o_ws_result,
  output logic                                    o_ws_csr_wen,
  output logic [rv_exec_pkg::CSR_ADDR_WD-1:0]     o_ws_csr_addr,
  output logic [rv_exec_pkg::WORD_WD-1:0]         o_ws_csr_wdata,
  output logic                                    o_ws_ebreak,
  output logic                                    o_ws_invalid
);

  import rv_exec_pkg::*;

  logic                       ms_valid;
  logic [ES_TO_MS_BUS_WD-1:0] ms_bus;  // payload, only valid with ms_valid

  logic [GPR_ADDR_WD-1:0] ms_rd;
  logic [CSR_ADDR_WD-1:0] ms_csr;
  logic                   ms_gpr_wen;
  logic                   ms_csr_wen;
  logic                   ms_mem_ren;
  logic [2:0]             ms_mem_op;
  logic                   ms_csr_inst_sel;
  logic [WORD_WD-1:0]     ms_csrrdata;
  logic [WORD_WD-1:0]     ms_alu_result;
  logic [WORD_WD-1:0]     ms_csr_result;
  logic                   ms_ebreak;
  logic                   ms_invalid;
  logic [2:0]             ms_addr_low;
  logic [WORD_WD-1:0]     lane;
  logic [WORD_WD-1:0]     load_data;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      ms_valid <= 1'b0;
    end else begin
      ms_valid <= i_es_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_es_valid) begin
      ms_bus <= i_es_to_ms_bus;
    end
  end

  assign {ms_rd, ms_csr, ms_gpr_wen, ms_csr_wen, ms_mem_ren, ms_mem_op, ms_csr_inst_sel,
          ms_csrrdata, ms_alu_result, ms_csr_result,
          ms_ebreak, ms_invalid, ms_addr_low} = ms_bus;

  assign lane = i_data_sram_rdata >> {ms_addr_low, 3'b000};  // wanted bytes to bit 0

  always_comb begin
    unique case (ms_mem_op)
      MEM_B:   load_data = {{56{lane[7]}}, lane[7:0]};
      MEM_BU:  load_data = {56'b0, lane[7:0]};
      MEM_H:   load_data = {{48{lane[15]}}, lane[15:0]};
      MEM_HU:  load_data = {48'b0, lane[15:0]};
      MEM_W:   load_data = {{32{lane[31]}}, lane[31:0]};
      MEM_WU:  load_data = {32'b0, lane[31:0]};
      default: load_data = lane;  // ld
    endcase
  end

  always_comb begin
    if (ms_mem_ren) begin
      o_ws_result = load_data;
    end else if (ms_csr_inst_sel) begin
      o_ws_result = ms_csrrdata;  // csr read returns the old value
    end else begin
      o_ws_result = ms_alu_result;
    end
  end

  assign o_ws_valid     = ms_valid;
  assign o_ws_rd        = ms_rd;
  assign o_ws_gpr_wen   = ms_valid & ms_gpr_wen;
  assign o_ws_csr_wen   = ms_valid & ms_csr_wen;
  assign o_ws_csr_addr  = ms_csr;
  assign o_ws_csr_wdata = ms_csr_result;
  assign o_ws_ebreak    = ms_valid & ms_ebreak;
  assign o_ws_invalid   = ms_valid & ms_invalid;

endmodule

`default_nettype wire

//--- src/exec_mem_top.sv
// execute + memory with data sram; results come out one cycle after i_ex_valid, no back-pressure
`timescale 1ns/1ps
`default_nettype none

module exec_mem_top #(
  parameter int MEM_DEPTH = 512
) (
  input  logic                                    i_clk,
  input  logic                                    i_reset,
  input  logic                                    i_ex_valid,
  input  logic [rv_exec_pkg::DS_TO_ES_BUS_WD-1:0] i_ds_to_es_bus,
  output logic                                    o_ws_valid,
  output logic [rv_exec_pkg::GPR_ADDR_WD-1:0]     o_ws_rd,
  output logic                                    o_ws_gpr_wen,
  output logic [rv_exec_pkg::WORD_WD-1:0]         o_ws_result,
  output logic                                    o_ws_csr_wen,
  output logic [rv_exec_pkg::CSR_ADDR_WD-1:0]     o_ws_csr_addr,
  output logic [rv_exec_pkg::WORD_WD-1:0]         o_ws_csr_wdata,
  output logic                                    o_ws_ebreak,
  output logic                                    o_ws_invalid
);

  import rv_exec_pkg::*;

  logic                       es_valid;
  logic [ES_TO_MS_BUS_WD-1:0] es_to_ms_bus;
  logic [SRAM_ADDR_WD-1:0]    sram_addr;
  logic                       sram_ren;
  logic                       sram_wen;
  logic [SRAM_WMASK_WD-1:0]   sram_wmask;
  logic [WORD_WD-1:0]         sram_wdata;
  logic [WORD_WD-1:0]         sram_rdata;

  ex_stage u_ex_stage (
    .i_ex_valid        (i_ex_valid),
    .i_ds_to_es_bus    (i_ds_to_es_bus),
    .o_es_valid        (es_valid),
    .o_es_to_ms_bus    (es_to_ms_bus),
    .o_data_sram_addr  (sram_addr),
    .o_data_sram_ren   (sram_ren),
    .o_data_sram_wen   (sram_wen),
    .o_data_sram_wmask (sram_wmask),
    .o_data_sram_wdata (sram_wdata)
  );

  data_sram #(
    .MEM_DEPTH (MEM_DEPTH)
  ) u_data_sram (
    .i_clk   (i_clk),
    .i_addr  (sram_addr),
    .i_ren   (sram_ren),
    .i_wen   (sram_wen),
    .i_wmask (sram_wmask),
    .i_wdata (sram_wdata),
    .o_rdata (sram_rdata)
  );

  mem_stage u_mem_stage (
    .i_clk             (i_clk),
    .i_reset           (i_reset),
    .i_es_valid        (es_valid),
    .i_es_to_ms_bus    (es_to_ms_bus),
    .i_data_sram_rdata (sram_rdata),
    .o_ws_valid        (o_ws_valid),
    .o_ws_rd           (o_ws_rd),
    .o_ws_gpr_wen      (o_ws_gpr_wen),
    .o_ws_result       (o_ws_result),
    .o_ws_csr_wen      (o_ws_csr_wen),
    .o_ws_csr_addr     (o_ws_csr_addr),
    .o_ws_csr_wdata    (o_ws_csr_wdata),
    .o_ws_ebreak       (o_ws_ebreak),
    .o_ws_invalid      (o_ws_invalid)
  );

endmodule

`default_nettype wire

//--- bench/tb_exec_mem.sv
// self-checking testbench; loads and stores stay inside a 128 byte window at 0x200, filled first
`timescale 1ns/1ps
`default_nettype none

module tb_exec_mem;

  import rv_exec_pkg::*;

  localparam int CLK_PERIOD = 20;
  localparam int MEM_BASE   = 32'h200;
  localparam int WIN_WORDS  = 16;
  localparam int N_ALU      = 160;
  localparam int N_WORD     = 60;
  localparam int N_CSR      = 40;
  localparam int N_MEM      = 200;
  localparam int N_FLAG     = 12;
  // a store may pull a load right behind it
  localparam int N_TOTAL    = N_ALU + N_WORD + N_CSR + WIN_WORDS + 2 * N_MEM + N_FLAG;
  localparam int WATCHDOG_CYCLES = 4 * N_TOTAL + 100;

  logic                       clk;
  logic                       reset;
  logic                       ex_valid;
  logic [DS_TO_ES_BUS_WD-1:0] ds_bus;
  logic                       ws_valid;
  logic [GPR_ADDR_WD-1:0]     ws_rd;
  logic                       ws_gpr_wen;
  logic [WORD_WD-1:0]         ws_result;
  logic                       ws_csr_wen;
  logic [CSR_ADDR_WD-1:0]     ws_csr_addr;
  logic [WORD_WD-1:0]         ws_csr_wdata;
  logic                       ws_ebreak;
  logic                       ws_invalid;

  logic [31:0]                rng_state;
  logic [DS_TO_ES_BUS_WD-1:0] instr;  // instruction being built
  logic [7:0]                 mem_bytes [WIN_WORDS*8];
  logic [WORD_WD-1:0]         q_result [$];
  logic [WORD_WD-1:0]         q_csr_wdata [$];
  logic [20:0]                q_ctrl [$];  // rd, csr, gpr_wen, csr_wen, ebreak, invalid
  logic [WORD_WD-1:0]         exp_result;
  logic [WORD_WD-1:0]         exp_csr_wdata;
  logic [GPR_ADDR_WD-1:0]     exp_rd;
  logic [CSR_ADDR_WD-1:0]     exp_csr_addr;
  logic                       exp_gpr_wen;
  logic                       exp_csr_wen;
  logic                       exp_ebreak;
  logic                       exp_invalid;
  logic [4:0]                 word_ops [5] = '{ALU_ADD, ALU_SUB, ALU_SLL, ALU_SRL, ALU_SRA};
  int                         issued;
  int                         checked;

  exec_mem_top #(
    .MEM_DEPTH (512)
  ) DUT (
    .i_clk          (clk),
    .i_reset        (reset),
    .i_ex_valid     (ex_valid),
    .i_ds_to_es_bus (ds_bus),
    .o_ws_valid     (ws_valid),
    .o_ws_rd        (ws_rd),
    .o_ws_gpr_wen   (ws_gpr_wen),
    .o_ws_result    (ws_result),
    .o_ws_csr_wen   (ws_csr_wen),
    .o_ws_csr_addr  (ws_csr_addr),
    .o_ws_csr_wdata (ws_csr_wdata),
    .o_ws_ebreak    (ws_ebreak),
    .o_ws_invalid   (ws_invalid)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic abort_run();
    $display("TESTBENCH FAILED");
    $fatal(1, "run stopped at first failure");
  endtask

  function logic [31:0] rand32();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic logic [63:0] rand64();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = rand32();
    lo = rand32();
    return {hi, lo};
  endfunction

  function automatic int rand_below(input int n);
    logic [31:0] r;
    r = rand32();
    return int'(r % 32'(n));
  endfunction

  function automatic logic [63:0] alu_model(input logic [4:0] op, input logic [63:0] a,
                                            input logic [63:0] b, input logic wcut);
    logic [31:0] w;
    if (wcut) begin
      case (op)
        ALU_SUB: w = a[31:0] - b[31:0];
        ALU_SLL: w = a[31:0] << b[4:0];
        ALU_SRL: w = a[31:0] >> b[4:0];
        ALU_SRA: w = $signed(a[31:0]) >>> b[4:0];
        default: w = a[31:0] + b[31:0];
      endcase
      return {{32{w[31]}}, w};
    end
    case (op)
      ALU_ADD:  return a + b;
      ALU_SUB:  return a - b;
      ALU_SLL:  return a << b[5:0];
      ALU_SLT:  return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
      ALU_SLTU: return (a < b) ? 64'd1 : 64'd0;
      ALU_XOR:  return a ^ b;
      ALU_SRL:  return a >> b[5:0];
      ALU_SRA:  return $signed(a) >>> b[5:0];
      ALU_OR:   return a | b;
      ALU_AND:  return a & b;
      default:  return b;
    endcase
  endfunction

  function automatic logic [63:0] csr_model(input logic [2:0] op, input logic [63:0] old,
                                            input logic [63:0] mask);
    case (op)
      CSR_RW:  return mask;
      CSR_RS:  return old | mask;
      CSR_RC:  return old & ~mask;
      default: return old;
    endcase
  endfunction

  // little endian byte gather, then extend from the top byte read
  function automatic logic [63:0] load_model(input logic [31:0] addr, input logic [2:0] op);
    logic [63:0] raw;
    int          nbytes;
    int          pad;
    int          i;
    nbytes = 1 << op[1:0];
    pad    = 64 - 8 * nbytes;
    raw    = '0;
    for (i = 0; i < nbytes; i++) begin
      raw[8*i +: 8] = mem_bytes[addr - MEM_BASE + i];
    end
    if (op[2]) begin
      return raw;
    end
    return $signed(raw << pad) >>> pad;
  endfunction

  function automatic void store_model(input logic [31:0] addr, input logic [1:0] size,
                                      input logic [63:0] data);
    int i;
    for (i = 0; i < (1 << size); i++) begin
      mem_bytes[addr - MEM_BASE + i] = data[8*i +: 8];
    end
  endfunction

  function automatic logic [31:0] rand_addr(input int word, input int size);
    int off;
    off = rand_below(8) & ~((1 << size) - 1);  // aligned to size
    return 32'(MEM_BASE + 8 * word + off);
  endfunction

  function automatic logic [2:0] load_op(input int size);
    logic is_unsigned;
    is_unsigned = (size < 3) && (rand_below(2) == 1);
    return {is_unsigned, 2'(size)};
  endfunction

  // random data fields, add with rs1 and rs2, nothing enabled
  task automatic clear_instr();
    logic [31:0] tmp;
    tmp   = rand32();
    instr = '0;
    instr[DS_RS1DATA_LSB +: WORD_WD]  = rand64();
    instr[DS_RS2DATA_LSB +: WORD_WD]  = rand64();
    instr[DS_CSRRDATA_LSB +: WORD_WD] = rand64();
    instr[DS_IMM_LSB +: WORD_WD]      = rand64();
    instr[DS_PC_LSB +: WORD_WD]       = rand64();
    instr[DS_RD_LSB +: GPR_ADDR_WD]   = tmp[4:0];
    instr[DS_CSR_LSB +: CSR_ADDR_WD]  = tmp[16:5];
  endtask

  // model the instruction, queue what write-back must show, then drive it
  task automatic issue();
    logic [63:0] rs1;
    logic [63:0] csrr;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] alu_exp;
    logic [63:0] result_exp;
    logic [2:0]  mem_op;
    rs1    = instr[DS_RS1DATA_LSB +: WORD_WD];
    csrr   = instr[DS_CSRRDATA_LSB +: WORD_WD];
    mem_op = instr[DS_MEM_OP_LSB +: 3];
    a      = instr[DS_SRC1_SEL_LSB] ? instr[DS_PC_LSB +: WORD_WD] : rs1;
    case (instr[DS_SRC2_SEL_LSB +: 2])
      2'd0:    b = instr[DS_RS2DATA_LSB +: WORD_WD];
      2'd1:    b = instr[DS_IMM_LSB +: WORD_WD];
      default: b = 64'd4;
    endcase
    alu_exp = alu_model(instr[DS_ALU_OP_LSB +: 5], a, b, instr[DS_WORD_CUT_LSB]);
    if (instr[DS_MEM_WEN_LSB]) begin
      store_model(alu_exp[31:0], mem_op[1:0], instr[DS_RS2DATA_LSB +: WORD_WD]);
    end
    if (instr[DS_MEM_REN_LSB]) begin
      result_exp = load_model(alu_exp[31:0], mem_op);
    end else if (instr[DS_CSR_INST_LSB]) begin
      result_exp = csrr;
    end else begin
      result_exp = alu_exp;
    end
    q_result.push_back(result_exp);
    q_csr_wdata.push_back(csr_model(instr[DS_CSR_OP_LSB +: 3], csrr, rs1));
    q_ctrl.push_back({instr[DS_RD_LSB +: GPR_ADDR_WD], instr[DS_CSR_LSB +: CSR_ADDR_WD],
                      instr[DS_GPR_WEN_LSB], instr[DS_CSR_WEN_LSB],
                      instr[DS_EBREAK_LSB], instr[DS_INVALID_LSB]});
    @(posedge clk);
    ex_valid <= 1'b1;
    ds_bus   <= instr;
    issued++;
  endtask

  // strobes raised on an idle cycle must stay gated
  task automatic idle();
    @(posedge clk);
    ex_valid                <= 1'b0;
    ds_bus[DS_MEM_REN_LSB]  <= 1'b1;
    ds_bus[DS_MEM_WEN_LSB]  <= 1'b1;
    ds_bus[DS_GPR_WEN_LSB]  <= 1'b1;
  endtask

  task automatic gap();
    if (rand_below(3) == 0) begin
      idle();
    end
  endtask

  task automatic mem_access(input logic is_store, input logic [2:0] op, input logic [31:0] addr);
    logic [31:0] tmp;
    logic [63:0] imm;
    clear_instr();
    tmp = rand32();
    imm = {{52{tmp[11]}}, tmp[11:0]};
    instr[DS_IMM_LSB +: WORD_WD]     = imm;
    instr[DS_RS1DATA_LSB +: WORD_WD] = {32'b0, addr} - imm;  // rs1 + imm lands on addr
    instr[DS_SRC2_SEL_LSB +: 2]      = SRC2_IMM;
    instr[DS_MEM_OP_LSB +: 3]        = op;
    instr[DS_MEM_WEN_LSB]            = is_store;
    instr[DS_MEM_REN_LSB]            = !is_store;
    instr[DS_GPR_WEN_LSB]            = !is_store;
    issue();
  endtask

  // expected values move to stable registers mid-cycle
  always @(negedge clk) begin
    if (!reset && ws_valid) begin
      if (q_result.size() == 0) begin
        $display("o_ws_valid high at %0t with no instruction outstanding", $time);
        abort_run();
      end else begin
        exp_result    = q_result.pop_front();
        exp_csr_wdata = q_csr_wdata.pop_front();
        {exp_rd, exp_csr_addr, exp_gpr_wen, exp_csr_wen, exp_ebreak, exp_invalid} =
          q_ctrl.pop_front();
        checked++;
      end
    end
  end

  a_latency: assert property (@(posedge clk) disable iff (reset) ws_valid == $past(ex_valid))
    else begin
      $display("Error at %0t: o_ws_valid expected %0b got %0b", $time,
               !$sampled(ws_valid), $sampled(ws_valid));
      abort_run();
    end

  a_quiet: assert property (@(posedge clk) disable iff (reset)
    !ws_valid |-> !(ws_gpr_wen || ws_csr_wen || ws_ebreak || ws_invalid))
    else begin
      $display("Error at %0t: o_ws_gpr_wen/csr_wen/ebreak/invalid expected 0000 got %b", $time,
               {$sampled(ws_gpr_wen), $sampled(ws_csr_wen),
                $sampled(ws_ebreak), $sampled(ws_invalid)});
      abort_run();
    end

  a_result: assert property (@(posedge clk) disable iff (reset)
    ws_valid |-> ws_result == exp_result)
    else begin
      $display("Error at %0t: o_ws_result expected %h got %h", $time,
               exp_result, $sampled(ws_result));
      abort_run();
    end

  a_csr_wdata: assert property (@(posedge clk) disable iff (reset)
    ws_valid |-> ws_csr_wdata == exp_csr_wdata)
    else begin
      $display("Error at %0t: o_ws_csr_wdata expected %h got %h", $time,
               exp_csr_wdata, $sampled(ws_csr_wdata));
      abort_run();
    end

  a_rd: assert property (@(posedge clk) disable iff (reset) ws_valid |-> ws_rd == exp_rd)
    else begin
      $display("Error at %0t: o_ws_rd expected %0d got %0d", $time, exp_rd, $sampled(ws_rd));
      abort_run();
    end

  a_csr_addr: assert property (@(posedge clk) disable iff (reset)
    ws_valid |-> ws_csr_addr == exp_csr_addr)
    else begin
      $display("Error at %0t: o_ws_csr_addr expected %h got %h", $time,
               exp_csr_addr, $sampled(ws_csr_addr));
      abort_run();
    end

  a_gpr_wen: assert property (@(posedge clk) disable iff (reset)
    ws_valid |-> ws_gpr_wen == exp_gpr_wen)
    else begin
      $display("Error at %0t: o_ws_gpr_wen expected %0b got %0b", $time,
               exp_gpr_wen, $sampled(ws_gpr_wen));
      abort_run();
    end

  a_csr_wen: assert property (@(posedge clk) disable iff (reset)
    ws_valid |-> ws_csr_wen == exp_csr_wen)
    else begin
      $display("Error at %0t: o_ws_csr_wen expected %0b got %0b", $time,
               exp_csr_wen, $sampled(ws_csr_wen));
      abort_run();
    end

  a_ebreak: assert property (@(posedge clk) disable iff (reset)
    ws_valid |-> ws_ebreak == exp_ebreak)
    else begin
      $display("Error at %0t: o_ws_ebreak expected %0b got %0b", $time,
               exp_ebreak, $sampled(ws_ebreak));
      abort_run();
    end

  a_invalid: assert property (@(posedge clk) disable iff (reset)
    ws_valid |-> ws_invalid == exp_invalid)
    else begin
      $display("Error at %0t: o_ws_invalid expected %0b got %0b", $time,
               exp_invalid, $sampled(ws_invalid));
      abort_run();
    end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, run did not finish", WATCHDOG_CYCLES);
    abort_run();
  end

  initial begin
    int i;
    int word;
    int size;
    rng_state = 32'h8fe3;
    reset     = 1'b1;
    ex_valid  = 1'b0;
    ds_bus    = '0;
    instr     = '0;
    issued    = 0;
    checked   = 0;
    repeat (8) @(posedge clk);
    reset <= 1'b0;
    repeat (4) idle();  // nothing may come out before the first issue
    for (i = 0; i < N_ALU; i++) begin
      clear_instr();
      instr[DS_ALU_OP_LSB +: 5]   = 5'(rand_below(11));
      instr[DS_SRC1_SEL_LSB]      = 1'(rand_below(2));
      instr[DS_SRC2_SEL_LSB +: 2] = 2'(rand_below(3));  // rs2, imm or four
      instr[DS_GPR_WEN_LSB]       = 1'b1;
      issue();
      gap();
    end
    for (i = 0; i < N_WORD; i++) begin
      clear_instr();
      instr[DS_ALU_OP_LSB +: 5]   = word_ops[rand_below(5)];
      instr[DS_SRC2_SEL_LSB +: 2] = 2'(rand_below(2));
      instr[DS_WORD_CUT_LSB]      = 1'b1;
      instr[DS_GPR_WEN_LSB]       = 1'b1;
      issue();
      gap();
    end
    for (i = 0; i < N_CSR; i++) begin
      clear_instr();
      instr[DS_CSR_OP_LSB +: 3] = 3'(rand_below(4));
      instr[DS_CSR_INST_LSB]    = 1'b1;
      instr[DS_CSR_WEN_LSB]     = 1'b1;
      instr[DS_GPR_WEN_LSB]     = 1'b1;
      issue();
      gap();
    end
    for (i = 0; i < WIN_WORDS; i++) begin
      mem_access(1'b1, MEM_D, 32'(MEM_BASE + 8 * i));
      gap();
    end
    for (i = 0; i < N_MEM; i++) begin
      word = rand_below(WIN_WORDS);
      size = rand_below(4);
      if (rand_below(2) == 0) begin
        mem_access(1'b1, {1'b0, 2'(size)}, rand_addr(word, size));
        size = rand_below(4);
        if (rand_below(2) == 0) begin
          mem_access(1'b0, load_op(size), rand_addr(word, size));  // same word, no gap
        end
      end else begin
        mem_access(1'b0, load_op(size), rand_addr(word, size));
      end
      gap();
    end
    for (i = 0; i < N_FLAG; i++) begin
      clear_instr();
      instr[DS_EBREAK_LSB]  = i[0];
      instr[DS_INVALID_LSB] = i[1];
      issue();
      gap();
    end
    repeat (4) idle();
    if (checked == issued && q_result.size() == 0) begin
      $display("TESTBENCH PASSED");
      $finish;
    end else begin
      $display("only %0d of %0d results came out", checked, issued);
      abort_run();
    end
  end

endmodule

`default_nettype wire

//--- list.f
src/rv_exec_pkg.sv
src/ex_unit.sv
src/lsu_store.sv
src/data_sram.sv
src/ex_stage.sv
src/mem_stage.sv
src/exec_mem_top.sv
bench/tb_exec_mem.sv

//--- Makefile
TOOL       = verilator
TOP        = tb_exec_mem
FILELIST   = list.f
BUILD_DIR  = obj_dir
FLAGS      = --binary --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
LOG        = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)
	@echo "simulation ok"

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
